//--- vlog.f
source/mm_ram_types_pkg.sv
source/mm_ram_map_pkg.sv
source/dp_ram.sv
source/data_decoder.sv
source/sim_timer.sv
source/mm_ram.sv
tb/mm_ram_checker.sv
tb/tb_mm_ram.sv

//--- Bender.yml
package:
  name: mm_ram

sources:
  - source/mm_ram_types_pkg.sv
  - source/mm_ram_map_pkg.sv
  - source/dp_ram.sv
  - source/data_decoder.sv
  - source/sim_timer.sv
  - source/mm_ram.sv
  - target: test
    files:
      - tb/mm_ram_checker.sv
      - tb/tb_mm_ram.sv

//--- tb/tb_mm_ram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mm_ram;

  import mm_ram_types_pkg::*;
  import mm_ram_map_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int TIMER_N = 12;
  localparam int NUM_WORDS = 16;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      instr_req_i, instr_gnt_o, instr_rvalid_o;
  ram_addr_t instr_addr_i;
  fetch_t    instr_rdata_o;
  logic      data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
  bus_addr_t data_addr_i;
  be_t       data_be_i;
  word_t     data_wdata_i, data_rdata_o, exit_value_o;
  irq_id_t   irq_id_i;
  logic      irq_ack_i, irq_timer_o;
  logic      tests_passed_o, tests_failed_o, exit_valid_o;

  integer    seed;
  int        checks = 0;
  int        errors = 0;
  int        errors_before = 0;
  string     test_name = "reset";

  // byte model of the RAM and the responses still owed by the DUT
  logic [7:0] ref_mem [RAM_BYTES];
  word_t      data_exp_q[$];
  fetch_t     instr_exp_q[$];
  logic       data_gnt_d = 1'b0;
  logic       instr_req_d = 1'b0;

  // outputs seen in the grant cycle of the last data access
  logic       seen_passed, seen_failed, seen_exit;
  word_t      seen_exit_value;

  bus_addr_t  addrs [NUM_WORDS];
  ram_addr_t  fetch_addrs [6];

  mm_ram dut (.*);

  bind mm_ram mm_ram_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_addr_i    (data_addr_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o)
  );

  always #50 clk_i = ~clk_i;

  // little endian word at the aligned address
  function automatic word_t word_from_model(input bus_addr_t addr);
    ram_addr_t base;
    word_t     w;
    base = {addr[RAM_ADDR_WIDTH-1:2], 2'b00};
    for (int j = 0; j < BE_WIDTH; j++) begin
      w[8*j +: 8] = ref_mem[base + ram_addr_t'(j)];
    end
    return w;
  endfunction

  // sixteen bytes from addr with wrap at the top of the RAM
  function automatic fetch_t line_from_model(input ram_addr_t addr);
    fetch_t line;
    for (int i = 0; i < FETCH_BYTES; i++) begin
      line[8*i +: 8] = ref_mem[ram_addr_t'(addr + ram_addr_t'(i))];
    end
    return line;
  endfunction

  task automatic check_value(input string what, input logic [FETCH_WIDTH-1:0] expected,
                             input logic [FETCH_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // requests are recorded and responses compared at the falling edge
  always @(negedge clk_i) begin
    check_value("instr grant", instr_req_i, instr_gnt_o);
    if (!data_req_i) begin
      check_value("data grant without request", 1'b0, data_gnt_o);
    end
    if (data_rvalid_o !== data_gnt_d || instr_rvalid_o !== instr_req_d) begin
      $display("rvalid did not come one cycle after the grant in test %s", test_name);
      errors++;
    end
    if (data_rvalid_o) begin
      if (data_exp_q.size() == 0) begin
        $display("data rvalid without a pending request in test %s", test_name);
        errors++;
      end else begin
        check_value("data read", data_exp_q.pop_front(), data_rdata_o);
      end
    end
    if (instr_rvalid_o) begin
      if (instr_exp_q.size() == 0) begin
        $display("instruction rvalid without a pending fetch in test %s", test_name);
        errors++;
      end else begin
        check_value("fetch line", instr_exp_q.pop_front(), instr_rdata_o);
      end
    end
    if (data_req_i && data_gnt_o) begin
      if (!data_we_i && data_addr_i < bus_addr_t'(RAM_BYTES)) begin
        data_exp_q.push_back(word_from_model(data_addr_i));
      end else begin
        data_exp_q.push_back('0);
      end
      if (data_we_i && data_addr_i < bus_addr_t'(RAM_BYTES)) begin
        for (int j = 0; j < BE_WIDTH; j++) begin
          if (data_be_i[j]) begin
            ref_mem[{data_addr_i[RAM_ADDR_WIDTH-1:2], 2'(j)}] = data_wdata_i[8*j +: 8];
          end
        end
      end
    end
    if (instr_req_i) begin
      instr_exp_q.push_back(line_from_model(instr_addr_i));
    end
    data_gnt_d  = data_req_i && data_gnt_o;
    instr_req_d = instr_req_i;
  end

  // one request held until the grant is seen
  task automatic data_access(input logic we, input bus_addr_t addr, input be_t be,
                             input word_t wdata);
    int n;
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_we_i    <= we;
    data_addr_i  <= addr;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    n = 0;
    @(negedge clk_i);
    while (!data_gnt_o && n < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if (!data_gnt_o) begin
      $display("no grant for address %h in test %s", addr, test_name);
      errors++;
    end
    seen_passed     = tests_passed_o;
    seen_failed     = tests_failed_o;
    seen_exit       = exit_valid_o;
    seen_exit_value = exit_value_o;
  endtask

  task automatic bus_idle();
    @(posedge clk_i);
    data_req_i  <= 1'b0;
    data_we_i   <= 1'b0;
    instr_req_i <= 1'b0;
    irq_ack_i   <= 1'b0;
  endtask

  task automatic wait_responses();
    int n;
    n = 0;
    while ((data_exp_q.size() != 0 || instr_exp_q.size() != 0) && n < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
      $display("responses still missing at the end of test %s", test_name);
      errors++;
    end
  endtask

  task automatic acknowledge(input irq_id_t id);
    @(posedge clk_i);
    irq_ack_i <= 1'b1;
    irq_id_i  <= id;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic finish_test();
    wait_responses();
    $display("test %s finished with %0d errors", test_name, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    int   n;
    logic fired;
    seed = 68;
    rst_ni = 1'b0;
    instr_req_i = 1'b0;
    instr_addr_i = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_addr_i = '0;
    data_be_i = '0;
    data_wdata_i = '0;
    irq_id_i = '0;
    irq_ack_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_name = "ram_write_read";
    for (int i = 0; i < NUM_WORDS; i++) begin
      addrs[i] = bus_addr_t'($random(seed)) & bus_addr_t'(RAM_BYTES - 4);
      data_access(1'b1, addrs[i], 4'hf, $random(seed));
      data_access(1'b1, addrs[i], be_t'($random(seed)), $random(seed));
      bus_idle();
      data_access(1'b0, addrs[i], 4'hf, '0);
      bus_idle();
    end
    finish_test();

    test_name = "back_to_back_reads";
    for (int i = NUM_WORDS - 1; i >= 0; i--) begin
      data_access(1'b0, addrs[i], 4'hf, '0);
    end
    bus_idle();
    finish_test();

    // lines at the top of the RAM wrap around to address zero
    test_name = "fetch";
    fetch_addrs = '{16'hfffc, 16'hfff8, 16'hfff0, 16'h0000, 16'h1234, 16'h8000};
    fetch_addrs[4] = ram_addr_t'($random(seed)) & 16'hfffc;
    fetch_addrs[5] = ram_addr_t'($random(seed)) & 16'hfffc;
    foreach (fetch_addrs[i]) begin
      for (int k = 0; k < 4; k++) begin
        data_access(1'b1, bus_addr_t'(ram_addr_t'(fetch_addrs[i] + 4 * k)), 4'hf,
                    $random(seed));
      end
      bus_idle();
      @(posedge clk_i);
      instr_req_i  <= 1'b1;
      instr_addr_i <= fetch_addrs[i];
      bus_idle();
      wait_responses();
    end
    finish_test();

    test_name = "test_status";
    data_access(1'b1, ADDR_STATUS, 4'hf, STATUS_PASS_VALUE);
    check_value("pass pulse", 1, seen_passed);
    check_value("fail pulse", 0, seen_failed);
    data_access(1'b1, ADDR_STATUS, 4'hf, STATUS_FAIL_VALUE);
    check_value("pass pulse", 0, seen_passed);
    check_value("fail pulse", 1, seen_failed);
    data_access(1'b1, ADDR_EXIT, 4'hf, 32'h5a5a_0000 | word_t'($random(seed) & 16'hffff));
    check_value("exit valid", 1, seen_exit);
    check_value("exit value", data_wdata_i, seen_exit_value);
    data_access(1'b0, ADDR_PERIPH_READ, 4'hf, '0);
    bus_idle();
    @(posedge clk_i);
    data_req_i  <= 1'b1;
    data_we_i   <= 1'b1;
    data_addr_i <= 32'h3000_0000;
    @(negedge clk_i);
    check_value("unmapped write grant", 0, data_gnt_o);
    bus_idle();
    finish_test();

    test_name = "timer";
    data_access(1'b1, ADDR_TIMER_MASK, 4'hf, word_t'(1) << TIMER_IRQ_ID);
    data_access(1'b1, ADDR_TIMER_COUNT, 4'hf, word_t'(TIMER_N));
    bus_idle();
    n = 0;
    while (!irq_timer_o && n < TIMER_N + 2) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq_timer_o) begin
      $display("timer interrupt did not rise within %0d cycles", TIMER_N + 2);
      errors++;
    end
    acknowledge(5'd3);
    check_value("irq after other ack", 1, irq_timer_o);
    acknowledge(TIMER_IRQ_ID);
    check_value("irq after timer ack", 0, irq_timer_o);
    data_access(1'b1, ADDR_TIMER_MASK, 4'hf, '0);
    data_access(1'b1, ADDR_TIMER_COUNT, 4'hf, word_t'(TIMER_N));
    bus_idle();
    fired = 1'b0;
    repeat (2 * TIMER_N) begin
      @(negedge clk_i);
      fired = fired | irq_timer_o;
    end
    check_value("irq with mask cleared", 0, fired);
    finish_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/mm_ram_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mm_ram_checker (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        instr_req_i,
  input  wire logic                        instr_rvalid_o,
  input  wire logic                        data_req_i,
  input  wire logic                        data_we_i,
  input  wire mm_ram_types_pkg::bus_addr_t data_addr_i,
  input  wire logic                        data_gnt_o,
  input  wire logic                        data_rvalid_o,
  input  wire logic                        tests_passed_o,
  input  wire logic                        tests_failed_o
);

  import mm_ram_types_pkg::*;
  import mm_ram_map_pkg::*;

  logic mapped_wr;

  // addresses a data write may go to
  assign mapped_wr = (data_addr_i < bus_addr_t'(RAM_BYTES)) ||
                     (data_addr_i == ADDR_STATUS) || (data_addr_i == ADDR_EXIT) ||
                     (data_addr_i == ADDR_TIMER_MASK) || (data_addr_i == ADDR_TIMER_COUNT);

  unmapped_write_no_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && data_we_i && !mapped_wr) |-> !data_gnt_o)
    else $error("write to unmapped address %h was granted", data_addr_i);

  data_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_i && data_gnt_o) |=> data_rvalid_o)
    else $error("data rvalid missing one cycle after grant");

  instr_rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i |=> instr_rvalid_o)
    else $error("instruction rvalid missing one cycle after request");

  status_pulses_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tests_passed_o && tests_failed_o))
    else $error("passed and failed pulsed together");

endmodule

`default_nettype wire

//--- source/mm_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mm_ram (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // instruction port
  input  wire logic                        instr_req_i,
  input  wire mm_ram_types_pkg::ram_addr_t instr_addr_i,
  output      logic                        instr_gnt_o,
  output      logic                        instr_rvalid_o,
  output      mm_ram_types_pkg::fetch_t    instr_rdata_o,

  // data port
  input  wire logic                        data_req_i,
  input  wire logic                        data_we_i,
  input  wire mm_ram_types_pkg::bus_addr_t data_addr_i,
  input  wire mm_ram_types_pkg::be_t       data_be_i,
  input  wire mm_ram_types_pkg::word_t     data_wdata_i,
  output      logic                        data_gnt_o,
  output      logic                        data_rvalid_o,
  output      mm_ram_types_pkg::word_t     data_rdata_o,

  // interrupts
  input  wire mm_ram_types_pkg::irq_id_t   irq_id_i,
  input  wire logic                        irq_ack_i,
  output      logic                        irq_timer_o,

  // test status
  output      logic                        tests_passed_o,
  output      logic                        tests_failed_o,
  output      logic                        exit_valid_o,
  output      mm_ram_types_pkg::word_t     exit_value_o
);

  import mm_ram_types_pkg::*;

  // decoder to RAM
  logic      ram_req;
  logic      ram_we;
  ram_addr_t ram_addr;
  be_t       ram_be;
  word_t     ram_wdata;
  word_t     ram_rdata;

  // decoder to timer
  logic      timer_mask_we;
  logic      timer_count_we;
  word_t     timer_wdata;

  logic      instr_rvalid_q;

  // fetches are always accepted, the line comes back next cycle
  assign instr_gnt_o = instr_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_q <= 1'b0;
    end else begin
      instr_rvalid_q <= instr_req_i;
    end
  end

  assign instr_rvalid_o = instr_rvalid_q;

  data_decoder u_data_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_req_i       (data_req_i),
    .data_we_i        (data_we_i),
    .data_addr_i      (data_addr_i),
    .data_be_i        (data_be_i),
    .data_wdata_i     (data_wdata_i),
    .data_gnt_o       (data_gnt_o),
    .data_rvalid_o    (data_rvalid_o),
    .data_rdata_o     (data_rdata_o),
    .ram_req_o        (ram_req),
    .ram_we_o         (ram_we),
    .ram_addr_o       (ram_addr),
    .ram_be_o         (ram_be),
    .ram_wdata_o      (ram_wdata),
    .ram_rdata_i      (ram_rdata),
    .timer_mask_we_o  (timer_mask_we),
    .timer_count_we_o (timer_count_we),
    .timer_wdata_o    (timer_wdata),
    .tests_passed_o   (tests_passed_o),
    .tests_failed_o   (tests_failed_o),
    .exit_valid_o     (exit_valid_o),
    .exit_value_o     (exit_value_o)
  );

  sim_timer u_sim_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mask_we_i   (timer_mask_we),
    .count_we_i  (timer_count_we),
    .wdata_i     (timer_wdata),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .irq_timer_o (irq_timer_o)
  );

  dp_ram u_dp_ram (
    .clk_i        (clk_i),
    .fetch_en_i   (instr_req_i),
    .fetch_addr_i (instr_addr_i),
    .fetch_data_o (instr_rdata_o),
    .data_en_i    (ram_req),
    .data_we_i    (ram_we),
    .data_addr_i  (ram_addr),
    .data_be_i    (ram_be),
    .data_wdata_i (ram_wdata),
    .data_rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

//--- source/sim_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sim_timer (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,

  // register writes from the data decoder
  input  wire logic                      mask_we_i,
  input  wire logic                      count_we_i,
  input  wire mm_ram_types_pkg::word_t   wdata_i,

  // interrupt acknowledge from the core
  input  wire logic                      irq_ack_i,
  input  wire mm_ram_types_pkg::irq_id_t irq_id_i,

  output      logic                      irq_timer_o
);

  import mm_ram_types_pkg::*;
  import mm_ram_map_pkg::*;

  word_t mask_q;
  word_t count_q;
  logic  irq_q;

  logic  timer_wr;
  logic  expire;
  logic  ack_hit;

  // the countdown pauses in cycles with a register write
  assign timer_wr = mask_we_i || count_we_i;
  assign expire   = !timer_wr && (count_q == word_t'(1));
  assign ack_hit  = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q  <= '0;
      count_q <= '0;
    end else begin
      if (mask_we_i) begin
        mask_q <= wdata_i;
      end
      if (count_we_i) begin
        count_q <= wdata_i;
      end else if (!timer_wr && count_q != '0) begin
        count_q <= count_q - word_t'(1);
      end
    end
  end

  // acknowledge wins over a new expiry in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else if (ack_hit) begin
      irq_q <= 1'b0;
    end else if (expire && mask_q[TIMER_IRQ_ID]) begin
      irq_q <= 1'b1;
    end
  end

  assign irq_timer_o = irq_q;

endmodule

`default_nettype wire

//--- source/data_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module data_decoder (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,

  // data bus from the core
  input  wire logic                        data_req_i,
  input  wire logic                        data_we_i,
  input  wire mm_ram_types_pkg::bus_addr_t data_addr_i,
  input  wire mm_ram_types_pkg::be_t       data_be_i,
  input  wire mm_ram_types_pkg::word_t     data_wdata_i,
  output      logic                        data_gnt_o,
  output      logic                        data_rvalid_o,
  output      mm_ram_types_pkg::word_t     data_rdata_o,

  // RAM data port
  output      logic                        ram_req_o,
  output      logic                        ram_we_o,
  output      mm_ram_types_pkg::ram_addr_t ram_addr_o,
  output      mm_ram_types_pkg::be_t       ram_be_o,
  output      mm_ram_types_pkg::word_t     ram_wdata_o,
  input  wire mm_ram_types_pkg::word_t     ram_rdata_i,

  // timer register writes
  output      logic                        timer_mask_we_o,
  output      logic                        timer_count_we_o,
  output      mm_ram_types_pkg::word_t     timer_wdata_o,

  // test status
  output      logic                        tests_passed_o,
  output      logic                        tests_failed_o,
  output      logic                        exit_valid_o,
  output      mm_ram_types_pkg::word_t     exit_value_o
);

  import mm_ram_types_pkg::*;
  import mm_ram_map_pkg::*;

  data_target_e target;
  data_target_e target_q;
  logic         gnt_q;
  logic         we_q;

  logic         in_ram;
  logic         per_write;
  logic         per_read;
  logic         wr_req;
  logic         status_wr;

  assign wr_req = data_req_i && data_we_i;
  assign in_ram = data_addr_i < bus_addr_t'(RAM_BYTES);

  // peripheral registers are write only, except the dummy read location
  assign per_write = (data_addr_i == ADDR_STATUS) || (data_addr_i == ADDR_EXIT) ||
                     (data_addr_i == ADDR_TIMER_MASK) || (data_addr_i == ADDR_TIMER_COUNT);
  assign per_read  = data_addr_i == ADDR_PERIPH_READ;

  always_comb begin
    target = T_ERR;
    if (data_req_i) begin
      if (in_ram) begin
        target = T_RAM;
      end else if (data_we_i ? per_write : per_read) begin
        target = T_PER;
      end
    end
  end

  // unmapped requests simply stay ungranted
  assign data_gnt_o = data_req_i && (target != T_ERR);

  // RAM side
  assign ram_req_o   = target == T_RAM;
  assign ram_we_o    = ram_req_o && data_we_i;
  assign ram_addr_o  = data_addr_i[RAM_ADDR_WIDTH-1:0];
  assign ram_be_o    = data_be_i;
  assign ram_wdata_o = data_wdata_i;

  // timer side
  assign timer_mask_we_o  = wr_req && (data_addr_i == ADDR_TIMER_MASK);
  assign timer_count_we_o = wr_req && (data_addr_i == ADDR_TIMER_COUNT);
  assign timer_wdata_o    = data_wdata_i;

  // test status pulses, only during the write request cycle
  assign status_wr      = wr_req && (data_addr_i == ADDR_STATUS);
  assign tests_passed_o = status_wr && (data_wdata_i == STATUS_PASS_VALUE);
  assign tests_failed_o = status_wr && (data_wdata_i == STATUS_FAIL_VALUE);
  assign exit_valid_o   = wr_req && (data_addr_i == ADDR_EXIT);
  assign exit_value_o   = exit_valid_o ? data_wdata_i : '0;

  // response stage, one cycle behind the grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      target_q <= T_ERR;
      gnt_q    <= 1'b0;
      we_q     <= 1'b0;
    end else begin
      target_q <= target;
      gnt_q    <= data_gnt_o;
      we_q     <= data_we_i;
    end
  end

  assign data_rvalid_o = gnt_q;

  // RAM word for RAM reads, zero for writes and peripheral reads
  always_comb begin
    data_rdata_o = '0;
    if (target_q == T_RAM && !we_q) begin
      data_rdata_o = ram_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- source/dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dp_ram (
  input  wire logic                        clk_i,

  // instruction fetch port, read only
  input  wire logic                        fetch_en_i,
  input  wire mm_ram_types_pkg::ram_addr_t fetch_addr_i,
  output      mm_ram_types_pkg::fetch_t    fetch_data_o,

  // data port, word wide with byte enables
  input  wire logic                        data_en_i,
  input  wire logic                        data_we_i,
  input  wire mm_ram_types_pkg::ram_addr_t data_addr_i,
  input  wire mm_ram_types_pkg::be_t       data_be_i,
  input  wire mm_ram_types_pkg::word_t     data_wdata_i,
  output      mm_ram_types_pkg::word_t     data_rdata_o
);

  import mm_ram_types_pkg::*;

  logic [7:0] mem [RAM_BYTES];

  // data port always works on the word containing the address
  ram_addr_t word_base;

  assign word_base = {data_addr_i[RAM_ADDR_WIDTH-1:2], 2'b00};

  // fetch port
  // sixteen consecutive bytes, the address wraps at the top of the RAM
  always_ff @(posedge clk_i) begin
    if (fetch_en_i) begin
      for (int i = 0; i < FETCH_BYTES; i++) begin
        fetch_data_o[8*i +: 8] <= mem[fetch_addr_i + ram_addr_t'(i)];
      end
    end
  end

  // data port read
  always_ff @(posedge clk_i) begin
    if (data_en_i && !data_we_i) begin
      for (int j = 0; j < BE_WIDTH; j++) begin
        data_rdata_o[8*j +: 8] <= mem[word_base | ram_addr_t'(j)];
      end
    end
  end

  // data port write, only enabled byte lanes change
  always_ff @(posedge clk_i) begin
    if (data_en_i && data_we_i) begin
      for (int j = 0; j < BE_WIDTH; j++) begin
        if (data_be_i[j]) begin
          mem[word_base | ram_addr_t'(j)] <= data_wdata_i[8*j +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/mm_ram_map_pkg.sv
`default_nettype none

package mm_ram_map_pkg;

  // test status pseudo peripheral, write only
  localparam mm_ram_types_pkg::bus_addr_t ADDR_STATUS = 32'h2000_0000;
  localparam mm_ram_types_pkg::bus_addr_t ADDR_EXIT = 32'h2000_0004;

  // timer registers, write only
  localparam mm_ram_types_pkg::bus_addr_t ADDR_TIMER_MASK = 32'h1500_0000;
  localparam mm_ram_types_pkg::bus_addr_t ADDR_TIMER_COUNT = 32'h1500_0004;

  // dummy peripheral read, always returns zero
  localparam mm_ram_types_pkg::bus_addr_t ADDR_PERIPH_READ = 32'h1500_1000;

  // values written to ADDR_STATUS by the test program
  localparam mm_ram_types_pkg::word_t STATUS_PASS_VALUE = 32'd123456789;
  localparam mm_ram_types_pkg::word_t STATUS_FAIL_VALUE = 32'd1;

  // mask bit and acknowledge id of the timer interrupt
  localparam mm_ram_types_pkg::irq_id_t TIMER_IRQ_ID = 5'd7;

  // where a data request goes
  //   T_RAM  the dual-port RAM
  //   T_PER  one of the pseudo peripherals
  //   T_ERR  unmapped, never granted
  typedef enum logic [1:0] {
    T_RAM = 2'd0,
    T_PER = 2'd1,
    T_ERR = 2'd2
  } data_target_e;

endpackage

`default_nettype wire

//--- source/mm_ram_types_pkg.sv
`default_nettype none

package mm_ram_types_pkg;

  // byte address inside the RAM, 64 KiB in total
  localparam int unsigned RAM_ADDR_WIDTH = 16;
  localparam int unsigned RAM_BYTES = 2 ** RAM_ADDR_WIDTH;

  // full address as seen on the data bus
  localparam int unsigned BUS_ADDR_WIDTH = 32;

  // data port word and its byte lanes
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

  // instruction fetch line, four words wide
  localparam int unsigned FETCH_WIDTH = 128;
  localparam int unsigned FETCH_BYTES = FETCH_WIDTH / 8;

  // interrupt id as carried on the acknowledge interface
  localparam int unsigned IRQ_ID_WIDTH = 5;

  // data bus address
  typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;

  // byte address into the RAM array
  typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // data word and byte enables
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [BE_WIDTH-1:0] be_t;

  // one instruction line, byte 0 in the low bits
  typedef logic [FETCH_WIDTH-1:0] fetch_t;

  // interrupt id
  typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;

endpackage

`default_nettype wire
